//--- logic/adc_params.svh
`ifndef ADC_PARAMS_SVH
`define ADC_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// acquisition path sizing
//////////////////////////////////////////////////////////////////////

// bits per converter word
`define ADC_W_DATA 18

// active mux channels
`define ADC_N_CHAN 6

// log2 of samples per average
`define ADC_OSR_LOG2 2

`endif

//--- logic/adc_pkg.sv
`include "adc_params.svh"

package adc_pkg;

	//////////////////////////////////////////////////////////////////////
	// basic widths
	//////////////////////////////////////////////////////////////////////

	// index width, never below one bit
	localparam int CHAN_W = ($clog2(`ADC_N_CHAN) > 0) ? $clog2(`ADC_N_CHAN) : 1;

	typedef logic [CHAN_W-1:0] chan_idx_t;          // mux channel number
	typedef logic [`ADC_N_CHAN-1:0] chan_vec_t;     // one bit per channel
	typedef logic [`ADC_W_DATA-1:0] adc_word_t;     // one converter word

	//////////////////////////////////////////////////////////////////////
	// bundles
	//////////////////////////////////////////////////////////////////////

	// both converter buses of one conversion
	typedef struct packed {
		adc_word_t a;                               // bus a word
		adc_word_t b;                               // bus b word
	} adc_pair_t;

	// one block average for one channel
	typedef struct packed {
		chan_idx_t chan;                            // source channel
		adc_word_t avg_a;                           // truncated mean of bus a
		adc_word_t avg_b;                           // truncated mean of bus b
	} filt_sample_t;

endpackage

//--- logic/adc_controller.sv
`timescale 1ns/1ps
`include "adc_params.svh"

module adc_controller (
	input  logic               adc_clk,      // converter clock
	input  logic               reset_in,     // async, active high
	input  logic               enable,       // run the channel scan
	output adc_pkg::chan_idx_t adc_mux_sel,  // analog mux select
	input  adc_pkg::adc_pair_t adc_data,     // both converter buses
	output adc_pkg::adc_pair_t sample,       // held conversion
	output adc_pkg::chan_vec_t chan_valid    // one-hot valid level
);
	import adc_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// slot sequencing
	//////////////////////////////////////////////////////////////////////

	// two phases per slot plus idle while disabled
	localparam logic [1:0] PH_IDLE = 2'd0;     // mux parked on next channel
	localparam logic [1:0] PH_CAPT = 2'd1;     // mux settled, capture on this edge
	localparam logic [1:0] PH_GAP  = 2'd2;     // valid low, mux steps on

	localparam chan_idx_t LAST_CHAN = chan_idx_t'(`ADC_N_CHAN - 1);

	logic [1:0] phase;                         // current slot phase
	chan_idx_t  chan;                          // channel being converted
	chan_idx_t  chan_next;                     // round-robin successor

	// wrap after the last active channel
	always_comb begin
		if (chan == LAST_CHAN)
			chan_next = '0;
		else
			chan_next = chan + 1'b1;
	end

	assign adc_mux_sel = chan;                 // mux follows the slot channel

	//////////////////////////////////////////////////////////////////////
	// phase, channel and valid
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge adc_clk or posedge reset_in) begin
		if (reset_in) begin
			phase      <= PH_IDLE;
			chan       <= '0;                  // scan starts at channel 0
			chan_valid <= '0;
		end else begin
			case (phase)
				PH_IDLE: begin
					chan_valid <= '0;
					if (enable)
						phase <= PH_CAPT;      // mux already settled
				end
				PH_CAPT: begin
					// one-hot level for the captured channel
					chan_valid <= chan_vec_t'(1) << chan;
					phase      <= PH_GAP;      // slot always completes
				end
				PH_GAP: begin
					chan_valid <= '0;          // falling edge for the crossing
					chan       <= chan_next;   // next channel gets one cycle to settle
					if (enable)
						phase <= PH_CAPT;
					else
						phase <= PH_IDLE;
				end
				default: begin
					chan_valid <= '0;
					phase      <= PH_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// converter word capture
	//////////////////////////////////////////////////////////////////////

	// pair stays put until the next capture
	always_ff @(posedge adc_clk) begin
		if (phase == PH_CAPT)
			sample <= adc_data;
	end

endmodule

//--- logic/clk_sync.sv
`timescale 1ns/1ps

module clk_sync (
	input  logic               data_valid_rdc,  // system clock
	input  logic               reset_in,        // async, active high
	input  adc_pkg::chan_vec_t chan_valid,      // adc_clk domain valid
	input  adc_pkg::adc_pair_t sample,          // adc_clk domain pair
	output adc_pkg::chan_vec_t sync_valid,      // one-cycle pulse
	output adc_pkg::adc_pair_t sync_sample      // pair in system domain
);
	import adc_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// strobe reduction and synchronizer
	//////////////////////////////////////////////////////////////////////

	logic strobe_any;                           // any channel valid
	logic strobe_meta;                          // first sync flop
	logic strobe_sync;                          // second sync flop

	assign strobe_any = |chan_valid;

	always_ff @(posedge data_valid_rdc or posedge reset_in) begin
		if (reset_in) begin
			strobe_meta <= 1'b0;
			strobe_sync <= 1'b0;
		end else begin
			strobe_meta <= strobe_any;          // may go metastable
			strobe_sync <= strobe_meta;         // settled copy
		end
	end

	//////////////////////////////////////////////////////////////////////
	// edge state machine
	//////////////////////////////////////////////////////////////////////

	localparam logic [1:0] ST_WAIT_PE = 2'd0;  // wait for strobe high
	localparam logic [1:0] ST_SEND    = 2'd1;  // pulse sync_valid
	localparam logic [1:0] ST_WAIT_NE = 2'd2;  // wait for strobe low

	logic [1:0] cur_state;
	logic [1:0] next_state;
	logic       load_en;                        // take data on leaving WAIT_PE

	always_ff @(posedge data_valid_rdc or posedge reset_in) begin
		if (reset_in)
			cur_state <= ST_WAIT_PE;
		else
			cur_state <= next_state;
	end

	always_comb begin
		next_state = cur_state;                 // hold by default
		case (cur_state)
			ST_WAIT_PE: if (strobe_sync)  next_state = ST_SEND;
			ST_SEND:                      next_state = ST_WAIT_NE;
			ST_WAIT_NE: if (!strobe_sync) next_state = ST_WAIT_PE;
			default:                      next_state = ST_WAIT_PE;
		endcase
	end

	assign load_en = (cur_state == ST_WAIT_PE) && strobe_sync;

	//////////////////////////////////////////////////////////////////////
	// data register
	//////////////////////////////////////////////////////////////////////

	chan_vec_t valid_q;                         // captured channel vector

	// sample has been stable since the valid rise two flops back
	always_ff @(posedge data_valid_rdc) begin
		if (load_en) begin
			valid_q     <= chan_valid;
			sync_sample <= sample;
		end
	end

	// pulse only in SEND
	assign sync_valid = valid_q & {$bits(chan_vec_t){cur_state == ST_SEND}};

endmodule

//--- logic/oversample_filter.sv
`timescale 1ns/1ps
`include "adc_params.svh"

module oversample_filter (
	input  logic                 data_valid_rdc,  // system clock
	input  logic                 reset_in,        // async, active high
	input  adc_pkg::chan_vec_t   sync_valid,      // one-hot sample pulse
	input  adc_pkg::adc_pair_t   sync_sample,     // pair for that channel
	output logic                 filt_valid,      // one-cycle result strobe
	output adc_pkg::filt_sample_t filt_out        // block average
);
	import adc_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// sizing
	//////////////////////////////////////////////////////////////////////

	// sum of a full block never overflows this width
	localparam int ACC_W = `ADC_W_DATA + `ADC_OSR_LOG2;
	// counts 0 up to block size - 1, never below one bit
	localparam int CNT_W = (`ADC_OSR_LOG2 > 0) ? `ADC_OSR_LOG2 : 1;

	// count value of the last sample in a block
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'((1 << `ADC_OSR_LOG2) - 1);

	//////////////////////////////////////////////////////////////////////
	// per-channel state
	//////////////////////////////////////////////////////////////////////

	logic [ACC_W-1:0] acc_a [`ADC_N_CHAN];     // running sum of bus a
	logic [ACC_W-1:0] acc_b [`ADC_N_CHAN];     // running sum of bus b
	logic [CNT_W-1:0] blk_cnt [`ADC_N_CHAN];   // samples so far in block

	chan_idx_t        pulse_chan;              // encoded pulse channel
	logic             pulse_any;               // some channel pulsed
	logic             blk_done;                // last sample of a block
	logic [ACC_W-1:0] sum_a;                   // sum including this sample
	logic [ACC_W-1:0] sum_b;

	// one-hot to index
	always_comb begin
		pulse_chan = '0;
		for (int i = 0; i < `ADC_N_CHAN; i++) begin
			if (sync_valid[i])
				pulse_chan = chan_idx_t'(i);
		end
	end

	assign pulse_any = |sync_valid;
	assign blk_done  = pulse_any && (blk_cnt[pulse_chan] == CNT_LAST);

	// words are unsigned, zero extend
	assign sum_a = acc_a[pulse_chan] + ACC_W'(sync_sample.a);
	assign sum_b = acc_b[pulse_chan] + ACC_W'(sync_sample.b);

	//////////////////////////////////////////////////////////////////////
	// block counters and result strobe
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge data_valid_rdc or posedge reset_in) begin
		if (reset_in) begin
			for (int i = 0; i < `ADC_N_CHAN; i++)
				blk_cnt[i] <= '0;
			filt_valid <= 1'b0;
		end else begin
			filt_valid <= blk_done;            // high for one cycle
			if (pulse_any) begin
				if (blk_done)
					blk_cnt[pulse_chan] <= '0; // block complete
				else
					blk_cnt[pulse_chan] <= blk_cnt[pulse_chan] + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// accumulators and averaged output
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge data_valid_rdc or posedge reset_in) begin
		if (reset_in) begin
			// every block starts from zero
			for (int i = 0; i < `ADC_N_CHAN; i++) begin
				acc_a[i] <= '0;
				acc_b[i] <= '0;
			end
			filt_out <= '0;
		end else if (pulse_any) begin
			if (blk_done) begin
				acc_a[pulse_chan] <= '0;       // ready for next block
				acc_b[pulse_chan] <= '0;
				filt_out.chan     <= pulse_chan;
				// divide by block size, truncating
				filt_out.avg_a    <= sum_a[ACC_W-1:`ADC_OSR_LOG2];
				filt_out.avg_b    <= sum_b[ACC_W-1:`ADC_OSR_LOG2];
			end else begin
				acc_a[pulse_chan] <= sum_a;
				acc_b[pulse_chan] <= sum_b;
			end
		end
	end

endmodule

//--- logic/adc_subsystem_top.sv
`timescale 1ns/1ps

module adc_subsystem_top (
	input  logic                  data_valid_rdc,  // system clock
	input  logic                  adc_clk,         // converter clock
	input  logic                  reset_in,        // async, active high
	input  logic                  enable,          // scan enable
	output adc_pkg::chan_idx_t    adc_mux_sel,     // to analog mux
	input  adc_pkg::adc_pair_t    adc_data,        // from converters
	output logic                  filt_valid,      // result strobe
	output adc_pkg::filt_sample_t filt_out         // block average
);
	import adc_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// inter-block buses
	//////////////////////////////////////////////////////////////////////

	chan_vec_t chan_valid;                      // adc_clk domain valid level
	adc_pair_t sample;                          // adc_clk domain pair
	chan_vec_t sync_valid;                      // system domain pulse
	adc_pair_t sync_sample;                     // system domain pair

	// converter sequencer
	adc_controller u_ctrl (
		.adc_clk     (adc_clk),
		.reset_in    (reset_in),
		.enable      (enable),
		.adc_mux_sel (adc_mux_sel),
		.adc_data    (adc_data),
		.sample      (sample),
		.chan_valid  (chan_valid)
	);

	// adc_clk to system clock crossing
	clk_sync u_sync (
		.data_valid_rdc (data_valid_rdc),
		.reset_in       (reset_in),
		.chan_valid     (chan_valid),
		.sample         (sample),
		.sync_valid     (sync_valid),
		.sync_sample    (sync_sample)
	);

	// block averaging
	oversample_filter u_filt (
		.data_valid_rdc (data_valid_rdc),
		.reset_in       (reset_in),
		.sync_valid     (sync_valid),
		.sync_sample    (sync_sample),
		.filt_valid     (filt_valid),
		.filt_out       (filt_out)
	);

endmodule

//--- tb/adc_subsystem_tb.sv
`timescale 1ns/1ps
`include "adc_params.svh"

module adc_subsystem_tb;
	import adc_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// DUT signals and reference state
	//////////////////////////////////////////////////////////////////////

	logic         data_valid_rdc;              // system clock, 10 ns
	logic         adc_clk;                     // converter clock, 30 ns
	logic         reset_in;
	logic         enable;
	chan_idx_t    adc_mux_sel;
	adc_pair_t    adc_data;
	logic         filt_valid;
	filt_sample_t filt_out;

	adc_pair_t    samp_q[$];                   // converter words in scan order
	chan_idx_t    samp_ch_q[$];                // channel named on each sample line
	filt_sample_t exp_q[$];                    // expected block averages
	int           n_samp;
	int           n_exp;
	int           n_results;                   // filt_valid pulses seen
	int           val_errs;                    // wrong values
	int           other_errs;                  // protocol and file trouble
	logic [31:0]  lcg_state;
	logic         vectors_loaded;
	logic         samples_done;                // last sample handed to the model

	adc_subsystem_top dut0 (
		.data_valid_rdc (data_valid_rdc),
		.adc_clk        (adc_clk),
		.reset_in       (reset_in),
		.enable         (enable),
		.adc_mux_sel    (adc_mux_sel),
		.adc_data       (adc_data),
		.filt_valid     (filt_valid),
		.filt_out       (filt_out)
	);

	always #5 data_valid_rdc = ~data_valid_rdc;
	always #15 adc_clk = ~adc_clk;             // unrelated to the system clock in phase

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	// numerical recipes constants
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic report_fault(input string msg);
		other_errs++;
		$display("at %0t ns: %s", $time, msg);
	endtask

	task automatic check_filt(input string name, input filt_sample_t exp, input filt_sample_t got);
		if (got !== exp) begin
			val_errs++;
			$display("ERR %0t %s exp %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_chan(input string name, input chan_idx_t exp, input chan_idx_t got);
		if (got !== exp) begin
			val_errs++;
			$display("ERR %0t %s exp %0d got %0d", $time, name, exp, got);
		end
	endtask

	// S lines feed the converter model, E lines the checker
	task automatic load_vectors();
		int               fd;
		int               code;
		int               ch;
		logic [63:0]      tok;
		logic [31:0]      wa;
		logic [31:0]      wb;
		logic [8*128-1:0] skip_buf;
		adc_pair_t        pr;
		filt_sample_t     fs;
		fd = $fopen("tb/adc_vectors.txt", "r");
		if (fd == 0) begin
			report_fault("could not open tb/adc_vectors.txt");
			return;
		end
		while (!$feof(fd)) begin
			tok = '0;
			code = $fscanf(fd, "%s", tok);
			if (code != 1)
				break;                             // end of file
			if (tok == "#") begin
				code = $fgets(skip_buf, fd);       // rest of a comment line
			end else if (tok == "S" || tok == "E") begin
				code = $fscanf(fd, "%d %h %h", ch, wa, wb);
				if (code != 3) begin
					report_fault("malformed line in vector file");
				end else if (tok == "S") begin
					pr.a = adc_word_t'(wa);
					pr.b = adc_word_t'(wb);
					samp_q.push_back(pr);
					samp_ch_q.push_back(chan_idx_t'(ch));
				end else begin
					fs.chan  = chan_idx_t'(ch);
					fs.avg_a = adc_word_t'(wa);
					fs.avg_b = adc_word_t'(wb);
					exp_q.push_back(fs);
				end
			end else begin
				report_fault("unknown line tag in vector file");
			end
		end
		$fclose(fd);
		n_samp = samp_q.size();
		n_exp  = exp_q.size();
		if (n_samp == 0)
			report_fault("vector file holds no sample lines");
	endtask

	//////////////////////////////////////////////////////////////////////
	// converter model and enable gaps
	//////////////////////////////////////////////////////////////////////

	// a new word goes out only when the mux moves, so a parked channel keeps its word
	initial begin : converter_model
		logic [31:0] rnd;
		chan_idx_t   drv_chan;
		logic        drv_started;
		int          gap_left;
		drv_started = 1'b0;
		gap_left    = 0;
		drv_chan    = '0;
		wait (vectors_loaded && !reset_in);
		forever begin
			@(negedge adc_clk);
			if (!samples_done && (!drv_started || adc_mux_sel != drv_chan)) begin
				if (!drv_started)
					check_chan("adc_mux_sel", '0, adc_mux_sel);  // scan starts at 0
				if (samp_ch_q[0] != adc_mux_sel)
					report_fault($sformatf("sample line for channel %0d met mux channel %0d",
						samp_ch_q[0], adc_mux_sel));
				adc_data = samp_q.pop_front();
				void'(samp_ch_q.pop_front());
				drv_chan    = adc_mux_sel;
				drv_started = 1'b1;
				if (samp_q.size() == 0) begin
					samples_done = 1'b1;           // stop after this slot
				end else if (samp_q.size() >= 2 && gap_left == 0) begin
					// no gap over the last two, so the final slot sees enable high
					rnd = lcg_next();
					if (rnd[31:30] == 2'd0)
						gap_left = 1 + int'(rnd[3:0] % 4);
				end
			end else if (gap_left > 0) begin
				gap_left--;
			end
			enable = !samples_done && (gap_left == 0);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// result monitor
	//////////////////////////////////////////////////////////////////////

	initial begin : result_monitor
		filt_sample_t exp;
		logic         prev_valid;
		prev_valid = 1'b0;
		forever begin
			@(negedge data_valid_rdc);             // outputs settled mid-cycle
			if (filt_valid === 1'b1) begin
				if (prev_valid) begin
					report_fault("filt_valid stayed high for more than one cycle");
				end else begin
					n_results++;
					if (exp_q.size() == 0) begin
						report_fault("filter gave a result with no expected line left");
					end else begin
						exp = exp_q.pop_front();
						check_chan("filt_out.chan", exp.chan, filt_out.chan);
						check_filt("filt_out", exp, filt_out);
					end
				end
			end else if (filt_valid !== 1'b0) begin
				report_fault("filt_valid is unknown");
			end
			prev_valid = (filt_valid === 1'b1);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// watchdog and main sequence
	//////////////////////////////////////////////////////////////////////

	// two slots of 60 ns per sample line, plus margin
	initial begin : watchdog
		wait (vectors_loaded);
		#(n_samp * 120 + 2000);
		$display("timeout: the run did not finish in the allowed time");
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin : main_seq
		int waited;
		data_valid_rdc = 1'b0;
		adc_clk        = 1'b0;
		reset_in       = 1'b1;
		enable         = 1'b0;
		adc_data       = '0;
		lcg_state      = 32'h2c8b2f90;
		n_samp         = 0;
		n_exp          = 0;
		n_results      = 0;
		val_errs       = 0;
		other_errs     = 0;
		vectors_loaded = 1'b0;
		samples_done   = 1'b0;
		load_vectors();
		samples_done   = (n_samp == 0);
		vectors_loaded = 1'b1;
		repeat (3) @(negedge data_valid_rdc);
		reset_in = 1'b0;
		wait (samples_done);
		waited = 0;
		while (exp_q.size() != 0 && waited < 200) begin
			@(negedge data_valid_rdc);
			waited++;
		end
		repeat (20) @(negedge data_valid_rdc); // room for a stray extra pulse
		if (exp_q.size() != 0)
			report_fault($sformatf("%0d expected results never came out", exp_q.size()));
		if (n_results != n_exp)
			report_fault($sformatf("saw %0d results, expected %0d", n_results, n_exp));
		$display("errors: %0d value, %0d other, %0d total",
			val_errs, other_errs, val_errs + other_errs);
		if (val_errs + other_errs == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- tb/adc_vectors.txt
# tag chan word_a word_b, words in hex, chan in decimal
# S = converter sample in scan order, E = expected block average
# block 1, round 0
S 0 3ffff 00000
S 1 2aaaa 15555
S 2 00001 3ffff
S 3 10000 12345
S 4 00001 3ffff
S 5 0abcd 00003
# block 1, round 1
S 0 3ffff 00000
S 1 15555 15555
S 2 00002 3fffe
S 3 20000 12346
S 4 00000 3ffff
S 5 0abcd 00003
# block 1, round 2
S 0 3ffff 00000
S 1 2aaaa 15555
S 2 00003 3fffd
S 3 30000 12347
S 4 00000 3ffff
S 5 0abcd 00003
# block 1, round 3
S 0 3ffff 00000
S 1 15555 15555
S 2 00004 3fffc
S 3 00000 12348
S 4 00000 3fffc
S 5 0abcd 00002
E 0 3ffff 00000
E 1 1ffff 15555
E 2 00002 3fffd
E 3 18000 12346
E 4 00000 3fffe
E 5 0abcd 00002
# block 2, round 0
S 0 00000 3ffff
S 1 3ffff 2aaaa
S 2 00100 00007
S 3 3fff0 20000
S 4 12345 00000
S 5 1ffff 3ffff
# block 2, round 1
S 0 00000 3ffff
S 1 00000 2aaaa
S 2 00200 00007
S 3 3fff1 20000
S 4 23456 00000
S 5 20000 3ffff
# block 2, round 2
S 0 00000 3ffff
S 1 3ffff 2aaaa
S 2 00300 00007
S 3 3fff2 20000
S 4 34567 00000
S 5 1ffff 3ffff
# block 2, round 3
S 0 00000 3ffff
S 1 00000 2aaaa
S 2 00400 00007
S 3 3fff3 20001
S 4 01234 00000
S 5 20000 3ffff
E 0 00000 3ffff
E 1 1ffff 2aaaa
E 2 00280 00007
E 3 3fff1 20000
E 4 1abcd 00000
E 5 1ffff 3ffff

//--- sources.f
+incdir+logic
logic/adc_pkg.sv
logic/adc_controller.sv
logic/clk_sync.sv
logic/oversample_filter.sv
logic/adc_subsystem_top.sv
tb/adc_subsystem_tb.sv
